// File: src/draw_params.svh
// Sizes and reset values shared by the drawing design.
// Include wherever a width or a reset shape value is needed.
`ifndef DRAW_PARAMS_SVH
`define DRAW_PARAMS_SVH

`define DRAW_FB_WIDTH    320  // framebuffer width in pixels
`define DRAW_FB_HEIGHT   180  // framebuffer height in pixels

`define DRAW_CORDW       16   // coordinate width
`define DRAW_CIDXW       4    // colour index width

`define DRAW_SIZE_RESET  16   // square side after reset
`define DRAW_SPEED_RESET 2    // pixels per frame after reset

`endif

// File: src/draw_pkg.sv
// Types for the shape drawing design: coordinates, colour index and the
// host command word, which is read as a place or a shape command.
`include "draw_params.svh"

package draw_pkg;

    typedef logic [`DRAW_CORDW-1:0] coord_t;  // unsigned screen coordinate
    typedef logic [`DRAW_CIDXW-1:0] cidx_t;   // palette index

    // op = 0, moves the square's top-left corner
    typedef struct packed {
        logic       op;
        logic [5:0] spare_hi;
        logic [8:0] x;         // 0..319
        logic [7:0] spare_lo;
        logic [7:0] y;         // 0..179
    } place_cmd_t;

    // op = 1, changes size, speed and base colour
    typedef struct packed {
        logic        op;
        logic [10:0] spare_hi;
        logic [7:0]  size;      // side in pixels
        logic [3:0]  speed;     // pixels per frame
        logic [3:0]  spare_lo;
        logic [3:0]  base_cidx;
    } shape_cmd_t;

    // top bit is op in both views
    typedef union packed {
        place_cmd_t place;
        shape_cmd_t shape;
    } cmd_word_u;

endpackage

// File: src/rect_if.sv
// Rectangle draw request from the sequencer to the fill engine.
// Four-phase: req up with fields stable, ack up after the last pixel,
// req down, then ack down.
`timescale 1ns/100ps

interface rect_if;

    logic             req;   // draw request, held until ack
    logic             ack;   // rectangle finished
    draw_pkg::coord_t x0;    // top-left corner
    draw_pkg::coord_t y0;
    draw_pkg::coord_t x1;    // bottom-right corner, inclusive
    draw_pkg::coord_t y1;
    draw_pkg::cidx_t  cidx;  // fill colour

    modport seq (
        output req,
        output x0,
        output y0,
        output x1,
        output y1,
        output cidx,
        input  ack
    );

    modport fill (
        input  req,
        input  x0,
        input  y0,
        input  x1,
        input  y1,
        input  cidx,
        output ack
    );

endinterface

// File: src/draw_cmd_decode.sv
// Host command port. Slave side of a four-phase req/ack handshake; each
// accepted word is a place or a shape command, chosen by its top bit.
`timescale 1ns/100ps
`include "draw_params.svh"

module draw_cmd_decode (
    input  logic                clk_100m,
    input  logic                reset,
    input  logic                cmd_req,    // word stable while high
    input  draw_pkg::cmd_word_u cmd_word,
    output logic                cmd_ack,
    output logic                pos_load,   // one-cycle strobe, place command
    output draw_pkg::coord_t    pos_x,
    output draw_pkg::coord_t    pos_y,
    output draw_pkg::coord_t    sq_size,
    output draw_pkg::coord_t    sq_speed,
    output logic                cidx_load,  // one-cycle strobe, shape command
    output draw_pkg::cidx_t     base_cidx
);

    logic accept;    // fresh request, ack still low
    logic is_shape;  // op bit, shared by both views

    assign accept   = cmd_req && !cmd_ack;
    assign is_shape = cmd_word.shape.op;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            cmd_ack   <= 1'b0;
            pos_load  <= 1'b0;
            cidx_load <= 1'b0;
            sq_size   <= draw_pkg::coord_t'(`DRAW_SIZE_RESET);
            sq_speed  <= draw_pkg::coord_t'(`DRAW_SPEED_RESET);
            base_cidx <= '0;
        end else begin
            pos_load  <= accept && !is_shape;
            cidx_load <= accept && is_shape;
            if (accept) begin
                cmd_ack <= 1'b1;           // captured this cycle
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;           // host has let go
            end
            if (accept && is_shape) begin  // used from next frame on
                sq_size   <= draw_pkg::coord_t'(cmd_word.shape.size);
                sq_speed  <= draw_pkg::coord_t'(cmd_word.shape.speed);
                base_cidx <= cmd_word.shape.base_cidx;
            end
        end
    end

    // place position, only meaningful with pos_load
    always_ff @(posedge clk_100m) begin
        if (accept && !is_shape) begin
            pos_x <= draw_pkg::coord_t'(cmd_word.place.x);
            pos_y <= draw_pkg::coord_t'(cmd_word.place.y);
        end
    end

endmodule

// File: src/square_motion.sv
// Square position and direction. Each frame pulse moves the square by its
// speed and bounces it off the framebuffer edges; a place load overrides.
`timescale 1ns/100ps
`include "draw_params.svh"

module square_motion (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             frame,     // one-cycle frame tick
    input  logic             pos_load,  // place command, wins over frame
    input  draw_pkg::coord_t pos_x,
    input  draw_pkg::coord_t pos_y,
    input  draw_pkg::coord_t sq_size,
    input  draw_pkg::coord_t sq_speed,
    output draw_pkg::coord_t sq_x,      // top-left corner
    output draw_pkg::coord_t sq_y
);

    logic             dx;      // 1 moves left
    logic             dy;      // 1 moves up
    logic             dx_next;
    logic             dy_next;
    draw_pkg::coord_t x_next;
    draw_pkg::coord_t y_next;

    // one axis, returns {dir, pos}
    function automatic logic [`DRAW_CORDW:0] bounce_step(
        input draw_pkg::coord_t pos,
        input logic             dir,
        input draw_pkg::coord_t limit,
        input draw_pkg::coord_t size,
        input draw_pkg::coord_t speed
    );
        logic [`DRAW_CORDW:0] step;
        if (pos >= limit - (size + speed)) begin
            step = {1'b1, pos - speed};          // far edge, turn back
        end else if (pos < speed) begin
            step = {1'b0, pos + speed};          // near edge, turn forward
        end else if (dir) begin
            step = {dir, pos - speed};
        end else begin
            step = {dir, pos + speed};
        end
        return step;
    endfunction

    always_comb begin
        {dx_next, x_next} = bounce_step(sq_x, dx, draw_pkg::coord_t'(`DRAW_FB_WIDTH),
                                        sq_size, sq_speed);
        {dy_next, y_next} = bounce_step(sq_y, dy, draw_pkg::coord_t'(`DRAW_FB_HEIGHT),
                                        sq_size, sq_speed);
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            sq_x <= '0;
            sq_y <= '0;
            dx   <= 1'b0;
            dy   <= 1'b0;
        end else if (pos_load) begin
            sq_x <= pos_x;
            sq_y <= pos_y;
            dx   <= 1'b0;  // right
            dy   <= 1'b0;  // down
        end else if (frame) begin
            sq_x <= x_next;
            sq_y <= y_next;
            dx   <= dx_next;
            dy   <= dy_next;
        end
    end

endmodule

// File: src/draw_sequencer.sv
// Starts one square draw per frame tick when idle. Owns the colour index,
// bumped once per draw, and is the master of the rect_if handshake.
`timescale 1ns/100ps

module draw_sequencer (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             frame,      // ignored unless idle
    input  draw_pkg::coord_t sq_x,
    input  draw_pkg::coord_t sq_y,
    input  draw_pkg::coord_t sq_size,
    input  logic             cidx_load,  // shape command seen
    input  draw_pkg::cidx_t  base_cidx,
    rect_if.seq              rect
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;

    state_t          state;
    draw_pkg::cidx_t cidx_cnt;   // colour of the last draw
    draw_pkg::cidx_t cidx_next;  // counter after any reload

    assign cidx_next = cidx_load ? base_cidx : cidx_cnt;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state    <= IDLE;
            rect.req <= 1'b0;
            cidx_cnt <= '0;
        end else begin
            cidx_cnt <= cidx_next;
            case (state)
                INIT: begin  // position has moved by now
                    cidx_cnt <= cidx_next + 1'b1;  // wraps at 16
                    rect.req <= 1'b1;
                    state    <= DRAW;
                end
                DRAW: begin
                    if (rect.ack) begin
                        rect.req <= 1'b0;
                        state    <= DONE;
                    end
                end
                DONE: begin
                    if (!rect.ack) begin  // handshake closed
                        state <= IDLE;
                    end
                end
                default: begin  // IDLE
                    if (frame) begin
                        state <= INIT;
                    end
                end
            endcase
        end
    end

    // rectangle fields, stable from INIT until req drops
    always_ff @(posedge clk_100m) begin
        if (state == INIT) begin
            rect.x0   <= sq_x;
            rect.y0   <= sq_y;
            rect.x1   <= sq_x + sq_size - draw_pkg::coord_t'(1);
            rect.y1   <= sq_y + sq_size - draw_pkg::coord_t'(1);
            rect.cidx <= cidx_next + 1'b1;
        end
    end

endmodule

// File: src/rect_fill.sv
// Filled rectangle engine. Latches a request, then writes one pixel per
// cycle that the framebuffer is not busy, left to right and top to bottom.
`timescale 1ns/100ps

module rect_fill (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             fb_busy,  // holds the pending pixel
    rect_if.fill             rect,
    output logic             fb_we,
    output draw_pkg::coord_t fb_x,
    output draw_pkg::coord_t fb_y,
    output draw_pkg::cidx_t  fb_cidx
);

    logic             active;  // a pixel is pending
    logic             start;
    logic             last_x;
    logic             last_y;
    draw_pkg::coord_t x0_q;    // row start
    draw_pkg::coord_t x1_q;
    draw_pkg::coord_t y1_q;

    assign start  = rect.req && !rect.ack && !active;
    assign fb_we  = active && !fb_busy;  // pixel written this cycle
    assign last_x = (fb_x == x1_q);
    assign last_y = (fb_y == y1_q);

    // control
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            active   <= 1'b0;
            rect.ack <= 1'b0;
        end else begin
            if (start) begin
                active <= 1'b1;
            end else if (fb_we && last_x && last_y) begin
                active   <= 1'b0;
                rect.ack <= 1'b1;  // final pixel out
            end
            if (rect.ack && !rect.req) begin
                rect.ack <= 1'b0;
            end
        end
    end

    // scan position and latched rectangle
    always_ff @(posedge clk_100m) begin
        if (start) begin
            x0_q    <= rect.x0;
            x1_q    <= rect.x1;
            y1_q    <= rect.y1;
            fb_x    <= rect.x0;
            fb_y    <= rect.y0;
            fb_cidx <= rect.cidx;
        end else if (fb_we) begin
            if (!last_x) begin
                fb_x <= fb_x + 1'b1;
            end else if (!last_y) begin  // next row
                fb_x <= x0_q;
                fb_y <= fb_y + 1'b1;
            end
        end
    end

endmodule

// File: src/shape_draw_top.sv
// Top level of the square drawing design: host command port in, pixel
// write stream out to an external framebuffer, all on clk_100m.
`timescale 1ns/100ps

module shape_draw_top (
    input  logic        clk_100m,
    input  logic        reset,
    input  logic        frame,     // frame tick, one cycle
    input  logic        cmd_req,
    input  logic [31:0] cmd_word,
    input  logic        fb_busy,
    output logic        cmd_ack,
    output logic        fb_we,
    output logic [15:0] fb_x,
    output logic [15:0] fb_y,
    output logic [3:0]  fb_cidx
);

    logic             pos_load;
    logic             cidx_load;
    draw_pkg::coord_t pos_x;
    draw_pkg::coord_t pos_y;
    draw_pkg::coord_t sq_size;
    draw_pkg::coord_t sq_speed;
    draw_pkg::coord_t sq_x;
    draw_pkg::coord_t sq_y;
    draw_pkg::cidx_t  base_cidx;

    rect_if rect ();  // sequencer to fill engine

    draw_cmd_decode u_decode (
        .clk_100m,
        .reset,
        .cmd_req,
        .cmd_word,
        .cmd_ack,
        .pos_load,
        .pos_x,
        .pos_y,
        .sq_size,
        .sq_speed,
        .cidx_load,
        .base_cidx
    );

    square_motion u_motion (
        .clk_100m,
        .reset,
        .frame,
        .pos_load,
        .pos_x,
        .pos_y,
        .sq_size,
        .sq_speed,
        .sq_x,
        .sq_y
    );

    draw_sequencer u_seq (
        .clk_100m,
        .reset,
        .frame,
        .sq_x,
        .sq_y,
        .sq_size,
        .cidx_load,
        .base_cidx,
        .rect (rect.seq)
    );

    rect_fill u_fill (
        .clk_100m,
        .reset,
        .fb_busy,
        .rect (rect.fill),
        .fb_we,
        .fb_x,
        .fb_y,
        .fb_cidx
    );

endmodule

// File: test/shape_draw_chk.sv
// Handshake and pixel-write assertions for the fill engine and the command
// decoder. Bound into both; the decoder copy has the pixel checks turned off.
`timescale 1ns/100ps

module shape_draw_chk #(
    parameter bit PIXEL_CHECKS = 1'b1  // off where there is no pixel port
) (
    input logic        clk_100m,
    input logic        reset,
    input logic        req,
    input logic        ack,
    input logic        pend,     // pixel waiting in the fill engine
    input logic        fb_busy,
    input logic        fb_we,
    input logic [35:0] pix       // {x, y, cidx}
);

    int fails = 0;

    if (PIXEL_CHECKS) begin : g_pixel
        // busy never drops the waiting pixel
        a_busy_hold: assert property (@(posedge clk_100m) disable iff (reset)
            pend && fb_busy |=> pend)
            else begin
                $error("pending pixel lost while framebuffer busy");
                fails++;
            end

        // held pixel keeps its place and colour
        a_pix_hold: assert property (@(posedge clk_100m) disable iff (reset)
            pend && !fb_we |=> $stable(pix))
            else begin
                $error("pending pixel changed before it was written");
                fails++;
            end
    end

    a_req_hold: assert property (@(posedge clk_100m) disable iff (reset)
        req && !ack |=> req)
        else begin
            $error("req dropped before ack");
            fails++;
        end

    a_ack_after_req: assert property (@(posedge clk_100m) disable iff (reset)
        $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            fails++;
        end

endmodule

bind rect_fill shape_draw_chk fill_chk (
    .clk_100m,
    .reset,
    .req     (rect.req),
    .ack     (rect.ack),
    .pend    (active),
    .fb_busy,
    .fb_we,
    .pix     ({fb_x, fb_y, fb_cidx})
);

bind draw_cmd_decode shape_draw_chk #(.PIXEL_CHECKS(1'b0)) cmd_chk (
    .clk_100m,
    .reset,
    .req     (cmd_req),
    .ack     (cmd_ack),
    .pend    (1'b0),
    .fb_busy (1'b0),
    .fb_we   (1'b0),
    .pix     ('0)
);

// File: test/shape_draw_tb.sv
// Directed tests for shape_draw_top. A framebuffer model logs every pixel
// write, and a reference model of the bounce and colour rules sets the expected squares.
`timescale 1ns/100ps
`include "draw_params.svh"

module shape_draw_tb;

    localparam int FRAMES    = 14;                     // frame pulses over all tests
    localparam int MAX_PIX   = 256;                    // biggest square is 16x16
    localparam int CYCLE_MAX = FRAMES * (MAX_PIX * 4 + 20) + 2000;
    localparam int FB_W      = `DRAW_FB_WIDTH;
    localparam int FB_H      = `DRAW_FB_HEIGHT;

    logic        clk_100m = 1'b0;
    logic        reset;
    logic        frame;
    logic        cmd_req;
    logic [31:0] cmd_word;
    logic        fb_busy;
    logic        cmd_ack;
    logic        fb_we;
    logic [15:0] fb_x;
    logic [15:0] fb_y;
    logic [3:0]  fb_cidx;

    logic [35:0] wr_log[$];                // {x, y, cidx} in write order
    int          fb_cnt[FB_W*FB_H];        // writes per pixel
    int          err_cnt   = 0;
    int          test_cnt  = 0;
    int          cycle_cnt = 0;
    logic [15:0] lfsr      = 16'd42777;
    logic        busy_rand = 1'b0;         // random back-pressure on

    int mx     = 0;                        // reference square corner
    int my     = 0;
    bit mdx    = 1'b0;                     // 1 moves left
    bit mdy    = 1'b0;                     // 1 moves up
    int msize  = `DRAW_SIZE_RESET;
    int mspeed = `DRAW_SPEED_RESET;
    int mcidx  = 0;                        // colour of the last draw

    always #5 clk_100m = ~clk_100m;

    shape_draw_top dut (.*);

    // Galois LFSR stepped once per bit
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    always @(posedge clk_100m) begin
        fb_busy <= busy_rand ? rand_bit() : 1'b0;
    end

    always @(posedge clk_100m) begin  // framebuffer model
        if (fb_we) begin
            wr_log.push_back({fb_x, fb_y, fb_cidx});
            if (fb_x < FB_W && fb_y < FB_H) begin
                fb_cnt[fb_y * FB_W + fb_x]++;
            end
        end
    end

    always @(posedge clk_100m) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_MAX) begin
            $display("timeout: run went past %0d cycles", CYCLE_MAX);
            $display("Errors found");
            $finish;
        end
    end

    task automatic mismatch(input string name, input string what,
                            input logic [35:0] exp, input logic [35:0] act);
        $display("Mismatch %s: %s expected 0x%0h actual 0x%0h", name, what, exp, act);
        err_cnt++;
    endtask

    task automatic report_test(input string name, input int err_start);
        test_cnt++;
        $display("test %s finished, %0d errors", name, err_cnt - err_start);
    endtask

    // one axis of the bounce rule
    task automatic bounce(inout int pos, inout bit neg, input int lim);
        if (pos >= lim - (msize + mspeed)) begin
            neg = 1'b1;
            pos = pos - mspeed;
        end else if (pos < mspeed) begin
            neg = 1'b0;
            pos = pos + mspeed;
        end else begin
            pos = neg ? pos - mspeed : pos + mspeed;
        end
    endtask

    function automatic draw_pkg::cmd_word_u place_word(input int x, input int y);
        draw_pkg::cmd_word_u w;
        w         = '0;           // op 0
        w.place.x = 9'(x);
        w.place.y = 8'(y);
        return w;
    endfunction

    function automatic draw_pkg::cmd_word_u shape_word(input int s, input int v, input int c);
        draw_pkg::cmd_word_u w;
        w                 = '0;
        w.shape.op        = 1'b1;
        w.shape.size      = 8'(s);
        w.shape.speed     = 4'(v);
        w.shape.base_cidx = 4'(c);
        return w;
    endfunction

    task automatic send_cmd(input string name, input draw_pkg::cmd_word_u w);
        int n;
        @(posedge clk_100m);
        cmd_req  <= 1'b1;
        cmd_word <= w;
        n = 0;
        do begin
            @(posedge clk_100m);
            n++;
        end while (!cmd_ack && n < 10);
        assert (cmd_ack) else begin
            $display("%s: cmd_ack did not rise within 10 cycles of cmd_req", name);
            err_cnt++;
        end
        cmd_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_100m);
            n++;
        end while (cmd_ack && n < 10);
        assert (!cmd_ack) else begin
            $display("%s: cmd_ack stayed high after cmd_req dropped", name);
            err_cnt++;
        end
    endtask

    // one frame tick and the matching model step
    task automatic send_frame(input bit draws);
        @(posedge clk_100m);
        frame <= 1'b1;
        @(posedge clk_100m);
        frame <= 1'b0;
        bounce(mx, mdx, FB_W);
        bounce(my, mdy, FB_H);
        if (draws) begin
            mcidx = (mcidx + 1) % 16;
        end
    endtask

    task automatic wait_draw();  // full rect_if handshake
        do @(posedge clk_100m); while (!dut.rect.ack);
        do @(posedge clk_100m); while (dut.rect.ack);
    endtask

    // expects row-major order and one write per pixel before clearing the model
    task automatic check_draw(input string name, input int x0, input int y0,
                              input int side, input int c);
        int          idx;
        logic [35:0] exp;
        idx = 0;
        assert (wr_log.size() == side * side)
            else mismatch(name, "write count", side * side, wr_log.size());
        for (int py = y0; py < y0 + side; py++) begin
            for (int px = x0; px < x0 + side; px++) begin
                exp = {16'(px), 16'(py), 4'(c)};
                if (idx < wr_log.size()) begin
                    assert (wr_log[idx] == exp)
                        else mismatch(name, "pixel {x,y,cidx}", exp, wr_log[idx]);
                end
                assert (fb_cnt[py * FB_W + px] == 1)
                    else mismatch(name, "writes to one pixel", 1, fb_cnt[py * FB_W + px]);
                idx++;
            end
        end
        wr_log.delete();
        foreach (fb_cnt[i]) begin
            fb_cnt[i] = 0;
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = err_cnt;
        repeat (50) begin
            @(posedge clk_100m);
            assert (!fb_we && !cmd_ack) else begin
                $display("idle_after_reset: fb_we or cmd_ack went high with no stimulus");
                err_cnt++;
            end
        end
        report_test("idle_after_reset", e0);
    endtask

    task automatic first_frame_draw();
        int e0;
        e0 = err_cnt;
        send_frame(1'b1);
        wait_draw();
        check_draw("first_frame_draw", 2, 2, 16, 1);  // (2,2) to (17,17) in colour 1
        report_test("first_frame_draw", e0);
    endtask

    task automatic place_and_shape();
        int e0;
        e0 = err_cnt;
        send_cmd("place_and_shape", place_word(100, 50));
        mx  = 100;
        my  = 50;
        mdx = 1'b0;
        mdy = 1'b0;
        send_cmd("place_and_shape", shape_word(8, 3, 5));
        msize  = 8;
        mspeed = 3;
        mcidx  = 5;
        repeat (2) @(posedge clk_100m);
        send_frame(1'b1);
        wait_draw();
        check_draw("place_and_shape", 103, 53, 8, 6);
        report_test("place_and_shape", e0);
    endtask

    task automatic edge_bounce();
        int e0;
        e0 = err_cnt;
        send_cmd("edge_bounce", place_word(305, 165));  // close to right and bottom
        mx  = 305;
        my  = 165;
        mdx = 1'b0;
        mdy = 1'b0;
        repeat (6) begin
            send_frame(1'b1);
            wait_draw();
            check_draw("edge_bounce", mx, my, msize, mcidx);
            assert (dut.u_motion.dx == mdx && dut.u_motion.dy == mdy)
                else mismatch("edge_bounce", "direction {dx,dy}", {mdx, mdy},
                              {dut.u_motion.dx, dut.u_motion.dy});
            repeat (8) @(posedge clk_100m);  // idle gap
        end
        report_test("edge_bounce", e0);
    endtask

    task automatic random_busy();
        int e0;
        e0 = err_cnt;
        send_cmd("random_busy", shape_word(12, 2, 9));
        msize  = 12;
        mspeed = 2;
        mcidx  = 9;
        @(posedge clk_100m);
        busy_rand <= 1'b1;
        repeat (3) begin
            send_frame(1'b1);
            wait_draw();
            check_draw("random_busy", mx, my, msize, mcidx);
        end
        busy_rand <= 1'b0;
        repeat (4) @(posedge clk_100m);
        report_test("random_busy", e0);
    endtask

    task automatic frame_during_draw();
        int e0;
        int ex;
        int ey;
        int ec;
        e0 = err_cnt;
        send_frame(1'b1);
        ex = mx;
        ey = my;
        ec = mcidx;
        do @(posedge clk_100m); while (!dut.rect.req);
        send_frame(1'b0);  // lands mid-draw and only moves the square
        wait_draw();
        check_draw("frame_during_draw", ex, ey, msize, ec);
        repeat (30) @(posedge clk_100m);
        assert (wr_log.size() == 0)
            else mismatch("frame_during_draw", "writes after ignored frame", 0, wr_log.size());
        send_frame(1'b1);
        wait_draw();
        check_draw("frame_during_draw", mx, my, msize, mcidx);
        report_test("frame_during_draw", e0);
    endtask

    initial begin
        reset    = 1'b1;
        frame    = 1'b0;
        cmd_req  = 1'b0;
        cmd_word = '0;
        fb_busy  = 1'b0;
        repeat (3) @(posedge clk_100m);
        reset <= 1'b0;
        idle_after_reset();
        first_frame_draw();
        place_and_shape();
        edge_bounce();
        random_busy();
        frame_during_draw();
        err_cnt += dut.u_fill.fill_chk.fails + dut.u_decode.cmd_chk.fails;
        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/draw_pkg.sv
src/rect_if.sv
src/draw_cmd_decode.sv
src/square_motion.sv
src/draw_sequencer.sv
src/rect_fill.sv
src/shape_draw_top.sv
test/shape_draw_chk.sv
test/shape_draw_tb.sv
